// ==== uart_echo.f ====
hdl/uart_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_echo.sv
tests/uart_echo_checker.sv
tests/uart_echo_tb.sv

// ==== Makefile ====
TOP       ?= uart_echo_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= uart_echo.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/uart_echo_tb.sv ====
`timescale 1ns/1ps

module uart_echo_tb;

	import uart_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 3;
	localparam int BIT_CYCLES   = OVERSAMPLE * CLKS_PER_TICK;
	localparam int TOTAL_BYTES  = 1 + 20 + FIFO_DEPTH + FIFO_DEPTH + 2;
	// Three frame times per byte, plus reset
	localparam int TIMEOUT_NS   =
		(TOTAL_BYTES * 10 * 3 * BIT_CYCLES + RESET_CYCLES) * CLK_PERIOD;

	logic        clk;
	logic        reset;
	logic        rx;
	logic        cts;
	logic        tx;
	logic        overflow;
	int          error_count;
	int          tx_count;
	logic [31:0] lfsr;

	uart_echo DUT
	(
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.cts      (cts),
		.tx       (tx),
		.overflow (overflow)
	);

	uart_echo_checker u_checker
	(
		.clk         (clk),
		.reset       (reset),
		.rx          (rx),
		.tx          (tx),
		.cts         (cts),
		.overflow    (overflow),
		.error_count (error_count),
		.tx_count    (tx_count)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// Right shifting Galois LFSR
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// One LFSR step per bit
	task automatic next_random_byte(output data_t value);
		for (int i = 0; i < DATA_BITS; i++)
		begin
			lfsr     = lfsr_next(lfsr);
			value[i] = lfsr[0];
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	endtask

	// One frame on rx, starts and ends on a falling edge
	task automatic send_byte(input data_t value);
		rx = 1'b0;
		repeat (BIT_CYCLES) @(negedge clk);
		for (int i = 0; i < DATA_BITS; i++)
		begin
			rx = value[i];
			repeat (BIT_CYCLES) @(negedge clk);
		end
		rx = 1'b1;
		repeat (BIT_CYCLES) @(negedge clk);
	endtask

	task automatic send_random_bytes(input int count);
		data_t value;
		for (int k = 0; k < count; k++)
		begin
			next_random_byte(value);
			send_byte(value);
		end
	endtask

	task automatic idle_bits(input int count);
		repeat (count * BIT_CYCLES) @(negedge clk);
	endtask

	// Blocks until the checker has decoded that many tx frames
	task automatic wait_for_tx(input int count);
		wait (tx_count >= count);
		@(negedge clk);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		rx   = 1'b1;
		cts  = 1'b1;
		lfsr = 32'd67289;
		apply_reset();
		idle_bits(2);

		// Single echo
		send_byte(8'hA5);
		wait_for_tx(1);

		// Back-to-back burst
		send_random_bytes(20);
		wait_for_tx(21);

		// Exactly fills the FIFO while held off
		cts = 1'b0;
		send_random_bytes(FIFO_DEPTH);
		idle_bits(4);
		cts = 1'b1;
		wait_for_tx(21 + FIFO_DEPTH);

		// Two extra bytes get dropped
		cts = 1'b0;
		send_random_bytes(FIFO_DEPTH + 2);
		idle_bits(4);
		cts = 1'b1;
		wait_for_tx(21 + 2 * FIFO_DEPTH);
		idle_bits(3);

		// Overflow clears only here
		apply_reset();
		idle_bits(1);

		$display("Errors: %0d, tx bytes: %0d", error_count, tx_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: echo traffic did not finish within %0d ns, %0d errors, %0d tx bytes",
			TIMEOUT_NS, error_count, tx_count);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== tests/uart_echo_checker.sv ====
`timescale 1ns/1ps

module uart_echo_checker
(
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  logic tx,
	input  logic cts,
	input  logic overflow,
	output int   error_count,
	output int   tx_count
);

	import uart_pkg::*;

	localparam int BIT_CYCLES = OVERSAMPLE * CLKS_PER_TICK;

	// Model queue, head at index started, tail at index accepted
	data_t model_bytes [int];
	int    accepted;
	int    started;
	logic  expect_overflow;
	logic  cts_prev;
	int    rx_errors;
	int    tx_errors;
	int    idle_errors;

	assign error_count = rx_errors + tx_errors + idle_errors;

	// A byte is stored only while the buffer has a free slot
	function automatic logic fifo_accepts(input int n_accepted, input int n_started);
		return (n_accepted - n_started) < FIFO_DEPTH;
	endfunction

	always @(posedge clk)
	begin
		cts_prev <= cts;
	end

	//////////////////////////////
	// Receive side and model
	//////////////////////////////

	initial
	begin : rx_decode
		data_t rx_byte;
		rx_errors = 0;
		accepted  = 0;
		forever
		begin
			@(posedge clk);
			if (reset)
			begin
				accepted        = 0;
				expect_overflow = 1'b0;
			end
			else if (rx === 1'b0)
			begin
				repeat (BIT_CYCLES / 2) @(posedge clk);
				for (int i = 0; i < DATA_BITS; i++)
				begin
					repeat (BIT_CYCLES) @(posedge clk);
					rx_byte[i] = rx;
				end
				// Mid stop bit
				repeat (BIT_CYCLES) @(posedge clk);
				if (fifo_accepts(accepted, started))
				begin
					model_bytes[accepted] = rx_byte;
					accepted++;
				end
				else
					expect_overflow = 1'b1;
				// DUT ends the same frame a few cycles later
				repeat (BIT_CYCLES / 4) @(posedge clk);
				if (overflow !== expect_overflow)
				begin
					$display("CHECK FAILED overflow expected %h actual %h",
						expect_overflow, overflow);
					rx_errors++;
				end
			end
		end
	end

	//////////////////////////////
	// Transmit side
	//////////////////////////////

	initial
	begin : tx_decode
		data_t tx_byte;
		data_t expected;
		logic  pending;
		tx_errors = 0;
		tx_count  = 0;
		started   = 0;
		forever
		begin
			@(posedge clk);
			if (reset)
				started = 0;
			else if (tx === 1'b0)
			begin
				if (cts_prev !== 1'b1)
				begin
					$display("Frame started on tx while cts was low at %0t", $time);
					tx_errors++;
				end
				repeat (BIT_CYCLES / 2 - 1) @(posedge clk);
				pending = (started < accepted);
				if (pending)
				begin
					expected = model_bytes[started];
					started++;
				end
				else
				begin
					expected = '0;
					$display("Frame on tx with no received byte pending at %0t", $time);
					tx_errors++;
				end
				for (int i = 0; i < DATA_BITS; i++)
				begin
					repeat (BIT_CYCLES) @(posedge clk);
					tx_byte[i] = tx;
				end
				repeat (BIT_CYCLES) @(posedge clk);
				if (tx !== 1'b1)
				begin
					$display("Stop bit on tx was not high at %0t", $time);
					tx_errors++;
				end
				if (pending && tx_byte !== expected)
				begin
					$display("CHECK FAILED tx_byte expected %h actual %h", expected, tx_byte);
					tx_errors++;
				end
				if (overflow !== expect_overflow)
				begin
					$display("CHECK FAILED overflow expected %h actual %h",
						expect_overflow, overflow);
					tx_errors++;
				end
				tx_count++;
			end
		end
	end

	// Line idles and overflow is clear after every reset
	initial
	begin : reset_state
		idle_errors = 0;
		forever
		begin
			@(negedge reset);
			repeat (4) @(posedge clk);
			if (tx !== 1'b1)
			begin
				$display("CHECK FAILED tx expected %h actual %h", 1'b1, tx);
				idle_errors++;
			end
			if (overflow !== 1'b0)
			begin
				$display("CHECK FAILED overflow expected %h actual %h", 1'b0, overflow);
				idle_errors++;
			end
		end
	end

endmodule

// ==== hdl/uart_echo.sv ====
`timescale 1ns/1ps

module uart_echo
(
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  logic cts,
	output logic tx,
	output logic overflow
);

	import uart_pkg::*;

	logic  tick;
	logic  rx_done;
	data_t rx_data;
	data_t rd_data;
	logic  pop;
	logic  empty;

	// Shared oversampling tick, same bit time both ways
	baud_tick_gen u_baud_tick_gen
	(
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	uart_rx u_uart_rx
	(
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.tick    (tick),
		.rx_done (rx_done),
		.rx_data (rx_data)
	);

	// Received bytes wait here while cts is low
	byte_fifo u_byte_fifo
	(
		.clk      (clk),
		.reset    (reset),
		.wr       (rx_done),
		.wr_data  (rx_data),
		.pop      (pop),
		.rd_data  (rd_data),
		.empty    (empty),
		.full     (),
		.overflow (overflow)
	);

	uart_tx u_uart_tx
	(
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.cts     (cts),
		.empty   (empty),
		.rd_data (rd_data),
		.pop     (pop),
		.tx      (tx)
	);

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
(
	input  logic            clk,
	input  logic            reset,
	input  logic            tick,
	input  logic            cts,
	input  logic            empty,
	input  uart_pkg::data_t rd_data,
	output logic            pop,
	output logic            tx
);

	import uart_pkg::*;

	tx_state_t   state;
	tx_state_t   state_next;
	tick_count_t tick_cnt;
	tick_count_t tick_cnt_next;
	bit_count_t  bit_cnt;
	bit_count_t  bit_cnt_next;
	data_t       shift_reg;
	data_t       shift_next;
	logic        tx_next;

	// Pop straight from idle, byte taken in the same cycle
	assign pop = (state == TX_IDLE) && cts && !empty;

	//////////////////////////////
	// State registers
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= TX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			shift_reg <= '0;
			tx        <= 1'b1;
		end
		else
		begin
			state     <= state_next;
			tick_cnt  <= tick_cnt_next;
			bit_cnt   <= bit_cnt_next;
			shift_reg <= shift_next;
			tx        <= tx_next;
		end
	end

	//////////////////////////////
	// Next state logic
	//////////////////////////////

	always_comb
	begin
		state_next    = state;
		tick_cnt_next = tick_cnt;
		bit_cnt_next  = bit_cnt;
		shift_next    = shift_reg;
		tx_next       = tx;

		case (state)
			TX_IDLE:
				if (pop)
				begin
					state_next    = TX_START;
					tick_cnt_next = '0;
					shift_next    = rd_data;
					tx_next       = 1'b0;
				end

			TX_START:
				if (tick)
				begin
					if (tick_cnt == tick_count_t'(OVERSAMPLE - 1))
					begin
						state_next    = TX_DATA;
						tick_cnt_next = '0;
						bit_cnt_next  = '0;
						tx_next       = shift_reg[0];
					end
					else
						tick_cnt_next = tick_cnt + 1'b1;
				end

			TX_DATA:
				if (tick)
				begin
					if (tick_cnt == tick_count_t'(OVERSAMPLE - 1))
					begin
						tick_cnt_next = '0;
						if (bit_cnt == bit_count_t'(DATA_BITS - 1))
						begin
							state_next = TX_STOP;
							tx_next    = 1'b1;
						end
						else
						begin
							// LSB first, next bit is the one above
							shift_next   = shift_reg >> 1;
							tx_next      = shift_reg[1];
							bit_cnt_next = bit_cnt + 1'b1;
						end
					end
					else
						tick_cnt_next = tick_cnt + 1'b1;
				end

			TX_STOP:
				if (tick)
				begin
					if (tick_cnt == tick_count_t'(OVERSAMPLE - 1))
						state_next = TX_IDLE;
					else
						tick_cnt_next = tick_cnt + 1'b1;
				end
		endcase
	end

	// Line idles high
	assert property (@(posedge clk) disable iff (reset) (state == TX_IDLE) |-> tx);

endmodule

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo
(
	input  logic            clk,
	input  logic            reset,
	input  logic            wr,
	input  uart_pkg::data_t wr_data,
	input  logic            pop,
	output uart_pkg::data_t rd_data,
	output logic            empty,
	output logic            full,
	output logic            overflow
);

	import uart_pkg::*;

	data_t       mem [FIFO_DEPTH];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_count_t count;
	logic        do_write;
	logic        do_pop;

	// A write into a full buffer is lost
	assign do_write = wr && !full;
	assign do_pop   = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == fifo_count_t'(FIFO_DEPTH));

	// Oldest entry always on the output
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= wr_data;
	end

	//////////////////////////////
	// Pointers and fill level
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// Pointers wrap naturally at FIFO_DEPTH
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_write, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sticky until the next reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overflow <= 1'b0;
		end
		else if (wr && full)
		begin
			overflow <= 1'b1;
		end
	end

	// Transmitter only pops what is there
	assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
(
	input  logic            clk,
	input  logic            reset,
	input  logic            rx,
	input  logic            tick,
	output logic            rx_done,
	output uart_pkg::data_t rx_data
);

	import uart_pkg::*;

	logic        rx_meta;
	logic        rx_sync;

	rx_state_t   state;
	rx_state_t   state_next;
	tick_count_t tick_cnt;
	tick_count_t tick_cnt_next;
	bit_count_t  bit_cnt;
	bit_count_t  bit_cnt_next;
	data_t       shift_reg;
	data_t       shift_next;

	assign rx_data = shift_reg;

	// Two-flop synchronizer, idles high like the line
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////////////
	// State registers
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= RX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			shift_reg <= '0;
		end
		else
		begin
			state     <= state_next;
			tick_cnt  <= tick_cnt_next;
			bit_cnt   <= bit_cnt_next;
			shift_reg <= shift_next;
		end
	end

	//////////////////////////////
	// Next state logic
	//////////////////////////////

	always_comb
	begin
		state_next    = state;
		tick_cnt_next = tick_cnt;
		bit_cnt_next  = bit_cnt;
		shift_next    = shift_reg;
		rx_done       = 1'b0;

		case (state)
			RX_IDLE:
				// Falling edge starts a frame
				if (!rx_sync)
				begin
					state_next    = RX_START;
					tick_cnt_next = '0;
				end

			RX_START:
				if (tick)
				begin
					// Half a bit in lands mid start bit
					if (tick_cnt == tick_count_t'(OVERSAMPLE / 2 - 1))
					begin
						state_next    = RX_DATA;
						tick_cnt_next = '0;
						bit_cnt_next  = '0;
					end
					else
						tick_cnt_next = tick_cnt + 1'b1;
				end

			RX_DATA:
				if (tick)
				begin
					if (tick_cnt == tick_count_t'(OVERSAMPLE - 1))
					begin
						tick_cnt_next = '0;
						// New bits enter at the MSB, so bit 0 ends at the bottom
						shift_next    = {rx_sync, shift_reg[DATA_BITS-1:1]};
						if (bit_cnt == bit_count_t'(DATA_BITS - 1))
							state_next = RX_STOP;
						else
							bit_cnt_next = bit_cnt + 1'b1;
					end
					else
						tick_cnt_next = tick_cnt + 1'b1;
				end

			RX_STOP:
				if (tick)
				begin
					// Mid stop bit, value not checked
					if (tick_cnt == tick_count_t'(OVERSAMPLE - 1))
					begin
						state_next = RX_IDLE;
						rx_done    = 1'b1;
					end
					else
						tick_cnt_next = tick_cnt + 1'b1;
				end
		endcase
	end

	// Done only ends a frame and hands control back to idle
	assert property (@(posedge clk) disable iff (reset)
		rx_done |-> (state == RX_STOP && tick) ##1 (state == RX_IDLE));

endmodule

// ==== hdl/baud_tick_gen.sv ====
`timescale 1ns/1ps

module baud_tick_gen
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	import uart_pkg::*;

	clk_div_t div_cnt;

	// Free running divider, wraps every CLKS_PER_TICK cycles
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			div_cnt <= '0;
		end
		else if (div_cnt == clk_div_t'(CLKS_PER_TICK - 1))
		begin
			div_cnt <= '0;
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// High for the single cycle in which the divider wraps
	assign tick = (div_cnt == clk_div_t'(CLKS_PER_TICK - 1));

endmodule

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

	//////////////////////////////
	// Frame format and timing
	//////////////////////////////

	// One start bit, DATA_BITS data bits LSB first, one stop bit
	localparam int DATA_BITS     = 8;
	localparam int OVERSAMPLE    = 16;
	// One bit time is OVERSAMPLE * CLKS_PER_TICK clk cycles
	localparam int CLKS_PER_TICK = 4;

	// Must stay a power of two
	localparam int FIFO_DEPTH    = 8;

	//////////////////////////////
	// Width types
	//////////////////////////////

	typedef logic [DATA_BITS-1:0]               data_t;
	typedef logic [$clog2(OVERSAMPLE)-1:0]      tick_count_t;
	typedef logic [$clog2(DATA_BITS)-1:0]       bit_count_t;
	typedef logic [$clog2(FIFO_DEPTH)-1:0]      fifo_ptr_t;
	typedef logic [$clog2(FIFO_DEPTH):0]        fifo_count_t;
	typedef logic [$clog2(CLKS_PER_TICK)-1:0]   clk_div_t;

	//////////////////////////////
	// State machines
	//////////////////////////////

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage
